// ==== include/rv32im_fetch_config.svh ====
`ifndef RV32IM_FETCH_CONFIG_SVH
`define RV32IM_FETCH_CONFIG_SVH

// Data and address width
`define RV32IM_XLEN 32

// RAM depth in words
`define RV32IM_MEM_WORDS 256

// External interrupt lines, line n maps to cause n+1
`define RV32IM_NUM_IRQ 4

`endif

// ==== design/rv32im_bus_pkg.sv ====
`default_nettype none

`include "rv32im_fetch_config.svh"

package rv32im_bus_pkg;

    // One bus data word
    typedef logic [`RV32IM_XLEN-1:0] word_t;

    // Word address, byte offset bits dropped
    typedef logic [`RV32IM_XLEN-3:0] word_adr_t;

    // Byte lane select
    typedef logic [3:0] sel_t;

endpackage

`default_nettype wire

// ==== design/rv32im_irq_pkg.sv ====
`default_nettype none

package rv32im_irq_pkg;

    // Index into the vector table
    typedef logic [2:0] cause_t;

    // Slot 0 holds the reset vector
    localparam cause_t CAUSE_RESET = 3'd0;

endpackage

`default_nettype wire

// ==== design/rv32im_prefetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32im_fetch_config.svh"

module rv32im_prefetch (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  rv32im_bus_pkg::word_t     program_counter_i,

    input  wire                       advance_i,
    output logic                      data_ready_o,
    output rv32im_bus_pkg::word_t     instruction_o,

    // Arbitration
    output logic                      ctrl_req_o,
    input  wire                       ctrl_grant_i,

    // Bus master side
    input  rv32im_bus_pkg::word_t     master_dat_i,
    input  wire                       ack_i,
    input  wire                       err_i,
    output rv32im_bus_pkg::word_adr_t adr_o,
    output logic                      cyc_o,
    output logic                      stb_o,
    output rv32im_bus_pkg::sel_t      sel_o,

    // Vector table
    input  wire                       interrupt_trigger_i,
    input  rv32im_bus_pkg::word_t     vtable_addr_i,
    input  rv32im_bus_pkg::word_t     vtable_offset_i,
    output rv32im_bus_pkg::word_t     interrupt_pc_o,
    output logic                      interrupt_pc_write_o,

    output logic                      initialized_o
);

    import rv32im_bus_pkg::*;

    logic vtable_done;
    logic irq_latched;
    logic vtable_cycle;
    logic start_vtable;
    logic start_fetch;
    logic bus_done;

    // Instruction fetches always read a full word
    assign sel_o = '1;
    assign cyc_o = stb_o;

    // Pending interrupt held until its vector is published
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_latched <= 1'b0;
        end else if (interrupt_pc_write_o) begin
            irq_latched <= 1'b0;
        end else if (interrupt_trigger_i) begin
            irq_latched <= 1'b1;
        end
    end

    // Reset vector first, then interrupts take the next advance
    assign start_vtable = ~ctrl_req_o & ~interrupt_pc_write_o
                        & (~vtable_done | (advance_i & irq_latched));
    assign start_fetch  = ~ctrl_req_o & vtable_done & advance_i
                        & ~(irq_latched & ~interrupt_pc_write_o);
    assign bus_done     = ctrl_req_o & ctrl_grant_i & (ack_i | err_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_req_o           <= 1'b0;
            stb_o                <= 1'b0;
            vtable_cycle         <= 1'b0;
            vtable_done          <= 1'b0;
            data_ready_o         <= 1'b0;
            interrupt_pc_write_o <= 1'b0;
            initialized_o        <= 1'b0;
        end else begin
            data_ready_o         <= 1'b0;
            interrupt_pc_write_o <= 1'b0;
            if (start_vtable) begin
                ctrl_req_o   <= 1'b1;
                stb_o        <= 1'b1;
                vtable_cycle <= 1'b1;
            end else if (start_fetch) begin
                ctrl_req_o   <= 1'b1;
                stb_o        <= 1'b1;
                vtable_cycle <= 1'b0;
            end else if (bus_done) begin
                ctrl_req_o <= 1'b0;
                stb_o      <= 1'b0;
                // An error ends the cycle with nothing published
                if (ack_i && vtable_cycle) begin
                    interrupt_pc_write_o <= 1'b1;
                    vtable_done          <= 1'b1;
                end else if (ack_i) begin
                    data_ready_o  <= 1'b1;
                    initialized_o <= 1'b1;
                end
            end
        end
    end

    // Address and returned data
    always_ff @(posedge clk_i) begin
        if (start_vtable) begin
            adr_o <= vtable_addr_i[`RV32IM_XLEN-1:2] + vtable_offset_i[`RV32IM_XLEN-1:2];
        end else if (start_fetch) begin
            adr_o <= program_counter_i[`RV32IM_XLEN-1:2];
        end
        if (bus_done && ack_i && vtable_cycle) begin
            interrupt_pc_o <= master_dat_i;
        end
        if (bus_done && ack_i && !vtable_cycle) begin
            instruction_o <= master_dat_i;
        end
    end

    // Strobe, request and address held until the bus cycle ends
    a_stb_held: assert property (@(posedge clk_i) disable iff (reset_i)
        stb_o && !bus_done |=> stb_o && ctrl_req_o && $stable(adr_o));

    a_pc_write_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        interrupt_pc_write_o |=> !interrupt_pc_write_o);

endmodule

`default_nettype wire

// ==== design/rv32im_irq_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32im_fetch_config.svh"

module rv32im_irq_regs (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire                          cfg_we_i,
    input  wire                          cfg_sel_i,
    input  rv32im_bus_pkg::word_t        cfg_data_i,
    input  wire [`RV32IM_NUM_IRQ-1:0]    irq_lines_i,
    input  wire                          initialized_i,
    input  wire                          pc_write_i,
    output rv32im_bus_pkg::word_t        vtable_base_o,
    output rv32im_bus_pkg::word_t        vtable_offset_o,
    output logic                         irq_trigger_o
);

    import rv32im_irq_pkg::*;

    logic [`RV32IM_NUM_IRQ-1:0] enable_q;
    logic [`RV32IM_NUM_IRQ-1:0] lines_q;
    logic [`RV32IM_NUM_IRQ-1:0] pending_q;
    logic [`RV32IM_NUM_IRQ-1:0] active;
    logic [`RV32IM_NUM_IRQ-1:0] clr_mask;
    cause_t                     sel_cause;
    cause_t                     offset_cause;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vtable_base_o <= '0;
            enable_q      <= '0;
        end else if (cfg_we_i) begin
            if (cfg_sel_i) begin
                enable_q <= cfg_data_i[`RV32IM_NUM_IRQ-1:0];
            end else begin
                vtable_base_o <= cfg_data_i;
            end
        end
    end

    assign active = pending_q & enable_q;

    // Lowest pending enabled cause wins
    always_comb begin
        sel_cause = CAUSE_RESET;
        clr_mask  = '0;
        for (int i = `RV32IM_NUM_IRQ - 1; i >= 0; i--) begin
            if (active[i]) begin
                sel_cause   = cause_t'(i + 1);
                clr_mask    = '0;
                clr_mask[i] = 1'b1;
            end
        end
    end

    // Rising edges set pending, serviced cause cleared on the PC write
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lines_q   <= '0;
            pending_q <= '0;
        end else begin
            lines_q   <= irq_lines_i;
            pending_q <= (pending_q & ~((pc_write_i && initialized_i) ? clr_mask : '0))
                       | (irq_lines_i & ~lines_q);
        end
    end

    // Reset slot until the first fetch has gone through
    assign offset_cause    = initialized_i ? sel_cause : CAUSE_RESET;
    assign vtable_offset_o = {{(`RV32IM_XLEN - $bits(cause_t) - 2){1'b0}}, offset_cause, 2'b00};
    assign irq_trigger_o   = |active;

endmodule

`default_nettype wire

// ==== design/rv32im_bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32im_bus_arbiter (
    input  wire                       clk_i,
    input  wire                       reset_i,

    // Fetch master
    input  wire                       fetch_req_i,
    input  wire                       fetch_stb_i,
    input  rv32im_bus_pkg::word_adr_t fetch_adr_i,
    input  rv32im_bus_pkg::sel_t      fetch_sel_i,
    output logic                      fetch_grant_o,
    output logic                      fetch_ack_o,
    output rv32im_bus_pkg::word_t     fetch_rdata_o,

    // Data master, higher priority
    input  wire                       dreq_i,
    input  wire                       dwe_i,
    input  rv32im_bus_pkg::word_adr_t dadr_i,
    input  rv32im_bus_pkg::word_t     ddat_i,
    output logic                      dack_o,
    output rv32im_bus_pkg::word_t     ddat_o,

    // RAM slave
    output logic                      ram_stb_o,
    output logic                      ram_we_o,
    output rv32im_bus_pkg::word_adr_t ram_adr_o,
    output rv32im_bus_pkg::word_t     ram_wdata_o,
    input  wire                       ram_ack_i,
    input  rv32im_bus_pkg::word_t     ram_rdata_i
);

    logic lock_fetch;
    logic lock_data;
    logic bus_free;
    logic data_grant;

    assign bus_free      = ~lock_fetch & ~lock_data;
    assign data_grant    = lock_data | (bus_free & dreq_i);
    assign fetch_grant_o = lock_fetch | (bus_free & ~dreq_i & fetch_req_i);

    // Owner held until its acknowledge
    always_ff @(posedge clk_i) begin
        if (reset_i || ram_ack_i) begin
            lock_fetch <= 1'b0;
            lock_data  <= 1'b0;
        end else if (bus_free) begin
            lock_data  <= dreq_i;
            lock_fetch <= ~dreq_i & fetch_req_i;
        end
    end

    // A fetch strobe with no byte lanes is no access
    assign ram_stb_o   = data_grant ? dreq_i : (fetch_grant_o & fetch_stb_i & |fetch_sel_i);
    assign ram_we_o    = data_grant & dwe_i;
    assign ram_adr_o   = data_grant ? dadr_i : fetch_adr_i;
    assign ram_wdata_o = ddat_i;

    assign dack_o        = ram_ack_i & data_grant;
    assign ddat_o        = ram_rdata_i;
    assign fetch_ack_o   = ram_ack_i & fetch_grant_o;
    assign fetch_rdata_o = ram_rdata_i;

    a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        !(fetch_grant_o && data_grant));

endmodule

`default_nettype wire

// ==== design/rv32im_wb_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32im_fetch_config.svh"

module rv32im_wb_ram (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       stb_i,
    input  wire                       we_i,
    input  rv32im_bus_pkg::word_adr_t adr_i,
    input  rv32im_bus_pkg::word_t     dat_i,
    output rv32im_bus_pkg::word_t     dat_o,
    output logic                      ack_o
);

    import rv32im_bus_pkg::*;

    localparam int IDX_W = $clog2(`RV32IM_MEM_WORDS);

    word_t            mem [`RV32IM_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;

    // Upper address bits ignored, the array wraps
    assign idx    = adr_i[IDX_W-1:0];
    assign access = stb_i & ~ack_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    // Read data lines up with the acknowledge
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                mem[idx] <= dat_i;
            end
            dat_o <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/rv32im_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32im_fetch_config.svh"

module rv32im_fetch_top (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  rv32im_bus_pkg::word_t     program_counter_i,
    input  wire                       advance_i,
    output logic                      fetch_valid_o,
    output rv32im_bus_pkg::word_t     instruction_o,
    input  wire [`RV32IM_NUM_IRQ-1:0] irq_lines_i,
    output rv32im_bus_pkg::word_t     irq_pc_o,
    output logic                      irq_pc_write_o,
    output logic                      initialized_o,

    // Data port
    input  wire                       dreq_i,
    input  wire                       dwe_i,
    input  rv32im_bus_pkg::word_adr_t dadr_i,
    input  rv32im_bus_pkg::word_t     ddat_i,
    output logic                      dack_o,
    output rv32im_bus_pkg::word_t     ddat_o,

    // Vector table configuration
    input  wire                       cfg_we_i,
    input  wire                       cfg_sel_i,
    input  rv32im_bus_pkg::word_t     cfg_data_i
);

    import rv32im_bus_pkg::*;

    logic      fetch_req;
    logic      fetch_stb;
    word_adr_t fetch_adr;
    sel_t      fetch_sel;
    logic      fetch_grant;
    logic      bus_ack;
    word_t     bus_rdata;
    logic      ram_stb;
    logic      ram_we;
    word_adr_t ram_adr;
    word_t     ram_wdata;
    logic      ram_ack;
    word_t     ram_rdata;
    word_t     vtable_base;
    word_t     vtable_offset;
    logic      irq_trigger;

    rv32im_prefetch u_prefetch (
        .clk_i (clk_i), .reset_i (reset_i),
        .program_counter_i (program_counter_i), .advance_i (advance_i),
        .data_ready_o (fetch_valid_o), .instruction_o (instruction_o),
        .ctrl_req_o (fetch_req), .ctrl_grant_i (fetch_grant),
        .master_dat_i (bus_rdata), .ack_i (bus_ack), .err_i (1'b0),
        .adr_o (fetch_adr), .cyc_o (), .stb_o (fetch_stb), .sel_o (fetch_sel),
        .interrupt_trigger_i (irq_trigger), .vtable_addr_i (vtable_base),
        .vtable_offset_i (vtable_offset), .interrupt_pc_o (irq_pc_o),
        .interrupt_pc_write_o (irq_pc_write_o), .initialized_o (initialized_o)
    );

    rv32im_irq_regs u_irq_regs (
        .clk_i (clk_i), .reset_i (reset_i),
        .cfg_we_i (cfg_we_i), .cfg_sel_i (cfg_sel_i), .cfg_data_i (cfg_data_i),
        .irq_lines_i (irq_lines_i), .initialized_i (initialized_o),
        .pc_write_i (irq_pc_write_o), .vtable_base_o (vtable_base),
        .vtable_offset_o (vtable_offset), .irq_trigger_o (irq_trigger)
    );

    rv32im_bus_arbiter u_arbiter (
        .clk_i (clk_i), .reset_i (reset_i),
        .fetch_req_i (fetch_req), .fetch_stb_i (fetch_stb), .fetch_adr_i (fetch_adr),
        .fetch_sel_i (fetch_sel), .fetch_grant_o (fetch_grant), .fetch_ack_o (bus_ack),
        .fetch_rdata_o (bus_rdata),
        .dreq_i (dreq_i), .dwe_i (dwe_i), .dadr_i (dadr_i), .ddat_i (ddat_i),
        .dack_o (dack_o), .ddat_o (ddat_o),
        .ram_stb_o (ram_stb), .ram_we_o (ram_we), .ram_adr_o (ram_adr),
        .ram_wdata_o (ram_wdata), .ram_ack_i (ram_ack), .ram_rdata_i (ram_rdata)
    );

    rv32im_wb_ram u_ram (
        .clk_i (clk_i), .reset_i (reset_i),
        .stb_i (ram_stb), .we_i (ram_we), .adr_i (ram_adr), .dat_i (ram_wdata),
        .dat_o (ram_rdata), .ack_o (ram_ack)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int RESET_CYCLES = 16;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32im_fetch_config.svh"

module tb_fetch_top;

    import rv32im_bus_pkg::*;

    localparam int    MEM_WORDS      = `RV32IM_MEM_WORDS;
    localparam int    TIMEOUT_CYCLES = 64;
    localparam int    IDLE_CYCLES    = 3;
    localparam int    MAX_ROWS       = 16;
    localparam word_t VTABLE_BASE    = 32'h0000_0100;
    localparam logic [`RV32IM_NUM_IRQ-1:0] IRQ_ENABLE = 4'b0111;

    localparam int KIND_FETCH   = 0;
    localparam int KIND_IRQ     = 1;
    localparam int KIND_WRITE   = 2;
    localparam int KIND_READ    = 3;
    localparam int KIND_CONTEND = 4;

    logic                       clk;
    logic                       reset;
    word_t                      program_counter;
    logic                       advance;
    logic                       fetch_valid;
    word_t                      instruction;
    logic [`RV32IM_NUM_IRQ-1:0] irq_lines;
    word_t                      irq_pc;
    logic                       irq_pc_write;
    logic                       initialized;
    logic                       dreq;
    logic                       dwe;
    word_adr_t                  dadr;
    word_t                      ddat_wr;
    logic                       dack;
    word_t                      ddat_rd;
    logic                       cfg_we;
    logic                       cfg_sel;
    word_t                      cfg_data;

    // Local image of the RAM contents
    word_t mirror [MEM_WORDS];

    // Stimulus table, one entry per index
    string                      row_name  [MAX_ROWS];
    int                         row_kind  [MAX_ROWS];
    word_t                      row_pc    [MAX_ROWS];
    word_adr_t                  row_dadr  [MAX_ROWS];
    logic [`RV32IM_NUM_IRQ-1:0] row_lines [MAX_ROWS];
    word_t                      row_data  [MAX_ROWS];
    word_t                      row_exp   [MAX_ROWS];
    int                         num_rows;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rv32im_fetch_top DUT (
        .clk_i (clk), .reset_i (reset),
        .program_counter_i (program_counter), .advance_i (advance),
        .fetch_valid_o (fetch_valid), .instruction_o (instruction),
        .irq_lines_i (irq_lines), .irq_pc_o (irq_pc),
        .irq_pc_write_o (irq_pc_write), .initialized_o (initialized),
        .dreq_i (dreq), .dwe_i (dwe), .dadr_i (dadr), .ddat_i (ddat_wr),
        .dack_o (dack), .ddat_o (ddat_rd),
        .cfg_we_i (cfg_we), .cfg_sel_i (cfg_sel), .cfg_data_i (cfg_data)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h",
                                        name, expected, actual));
        end
    endtask

    // Lands 1 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // RAM wraps on the low word address bits
    function automatic int ram_slot(input word_adr_t adr);
        return int'(adr % MEM_WORDS);
    endfunction

    function automatic word_t random_pc();
        return word_t'($urandom % MEM_WORDS) << 2;
    endfunction

    task automatic wait_dack();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            next_cycle();
            seen = dack;
        end
        if (!seen) begin
            stop_with_failure("Timeout waiting for the data port acknowledge");
        end
    endtask

    task automatic wait_fetch_valid();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            next_cycle();
            seen = fetch_valid;
        end
        if (!seen) begin
            stop_with_failure("Timeout waiting for a fetched instruction");
        end
    endtask

    task automatic wait_pc_write();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            next_cycle();
            seen = irq_pc_write;
        end
        if (!seen) begin
            stop_with_failure("Timeout waiting for a vector table load");
        end
    endtask

    // With keep_bus set the request stays up for a back-to-back access
    task automatic data_access(input logic we, input word_adr_t adr, input word_t wdat,
                               input logic keep_bus);
        dreq    = 1'b1;
        dwe     = we;
        dadr    = adr;
        ddat_wr = wdat;
        wait_dack();
        if (!keep_bus) begin
            dreq = 1'b0;
            dwe  = 1'b0;
        end
    endtask

    task automatic write_config(input logic sel, input word_t data);
        cfg_we   = 1'b1;
        cfg_sel  = sel;
        cfg_data = data;
        next_cycle();
        cfg_we   = 1'b0;
    endtask

    task automatic start_advance(input word_t pc);
        program_counter = pc;
        advance         = 1'b1;
        next_cycle();
        advance         = 1'b0;
    endtask

    task automatic add_row(input string name, input int kind, input word_t pc,
                           input word_adr_t dadr_val, input logic [`RV32IM_NUM_IRQ-1:0] lines,
                           input word_t data, input word_t expected);
        row_name[num_rows]  = name;
        row_kind[num_rows]  = kind;
        row_pc[num_rows]    = pc;
        row_dadr[num_rows]  = dadr_val;
        row_lines[num_rows] = lines;
        row_data[num_rows]  = data;
        row_exp[num_rows]   = expected;
        num_rows++;
    endtask

    // Expected values follow the mirror in table order
    task automatic build_table();
        word_adr_t vbase;
        word_adr_t wr_adr;
        word_adr_t rd_adr;
        word_t     wr_dat;
        word_t     pc;
        vbase    = VTABLE_BASE[`RV32IM_XLEN-1:2];
        num_rows = 0;
        pc = random_pc();
        add_row("fetch_first", KIND_FETCH, pc, '0, '0, '0, mirror[ram_slot(pc[31:2])]);
        pc = random_pc();
        add_row("fetch_random", KIND_FETCH, pc, '0, '0, '0, mirror[ram_slot(pc[31:2])]);
        wr_adr = word_adr_t'($urandom % MEM_WORDS);
        wr_dat = $urandom;
        add_row("data_write", KIND_WRITE, '0, wr_adr, '0, wr_dat, '0);
        mirror[ram_slot(wr_adr)] = wr_dat;
        pc = {wr_adr, 2'b00};
        add_row("fetch_after_write", KIND_FETCH, pc, '0, '0, '0, mirror[ram_slot(wr_adr)]);
        rd_adr = word_adr_t'($urandom % MEM_WORDS);
        add_row("data_read", KIND_READ, '0, rd_adr, '0, '0, mirror[ram_slot(rd_adr)]);
        // Line n takes vector slot n + 1
        add_row("irq_line0", KIND_IRQ, '0, '0, 4'b0001, '0, mirror[ram_slot(vbase + 1)]);
        add_row("irq_pair_low", KIND_IRQ, '0, '0, 4'b0110, '0, mirror[ram_slot(vbase + 2)]);
        add_row("irq_pair_high", KIND_IRQ, '0, '0, 4'b0000, '0, mirror[ram_slot(vbase + 3)]);
        pc = random_pc();
        add_row("disabled_line", KIND_FETCH, pc, '0, 4'b1000, '0, mirror[ram_slot(pc[31:2])]);
        pc     = random_pc();
        rd_adr = word_adr_t'($urandom % MEM_WORDS);
        add_row("fetch_contended", KIND_CONTEND, pc, rd_adr, '0, mirror[ram_slot(rd_adr)],
                mirror[ram_slot(pc[31:2])]);
    endtask

    task automatic apply_row(input int r);
        // Gap lets a pulsed line reach the prefetch latch
        irq_lines = row_lines[r];
        next_cycle();
        irq_lines = '0;
        repeat (IDLE_CYCLES) next_cycle();
        case (row_kind[r])
            KIND_FETCH: begin
                start_advance(row_pc[r]);
                wait_fetch_valid();
                check_value(row_name[r], row_exp[r], instruction);
                check_value("initialized", 32'd1, word_t'(initialized));
            end
            KIND_IRQ: begin
                start_advance(row_pc[r]);
                wait_pc_write();
                check_value(row_name[r], row_exp[r], irq_pc);
            end
            KIND_WRITE: begin
                data_access(1'b1, row_dadr[r], row_data[r], 1'b0);
            end
            KIND_READ: begin
                data_access(1'b0, row_dadr[r], '0, 1'b0);
                check_value(row_name[r], row_exp[r], ddat_rd);
            end
            KIND_CONTEND: begin
                // Data port is granted first, fetch waits for the bus
                program_counter = row_pc[r];
                advance         = 1'b1;
                data_access(1'b0, row_dadr[r], '0, 1'b0);
                advance         = 1'b0;
                check_value({row_name[r], "_data"}, row_data[r], ddat_rd);
                wait_fetch_valid();
                check_value(row_name[r], row_exp[r], instruction);
            end
            default: begin
                stop_with_failure("Unknown row kind in the stimulus table");
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'hf906_0e29));
        program_counter = '0;
        advance         = 1'b0;
        irq_lines       = '0;
        dreq            = 1'b0;
        dwe             = 1'b0;
        dadr            = '0;
        ddat_wr         = '0;
        cfg_we          = 1'b0;
        cfg_sel         = 1'b0;
        cfg_data        = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mirror[i] = $urandom;
        end
        // Loading starts under reset, the reset vector read waits behind it
        for (int i = 0; i < MEM_WORDS; i++) begin
            data_access(1'b1, word_adr_t'(i), mirror[i], 1'b1);
        end
        dreq = 1'b0;
        dwe  = 1'b0;
        wait_pc_write();
        check_value("reset_vector", mirror[0], irq_pc);
        check_value("init_before_fetch", 32'd0, word_t'(initialized));
        write_config(1'b0, VTABLE_BASE);
        write_config(1'b1, word_t'(IRQ_ENABLE));
        build_table();
        for (int r = 0; r < num_rows; r++) begin
            apply_row(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
design/rv32im_bus_pkg.sv
design/rv32im_irq_pkg.sv
design/rv32im_prefetch.sv
design/rv32im_irq_regs.sv
design/rv32im_bus_arbiter.sv
design/rv32im_wb_ram.sv
design/rv32im_fetch_top.sv
tests/tb_clock_gen.sv
tests/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: rv32im_fetch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rv32im_bus_pkg.sv
      - design/rv32im_irq_pkg.sv
      - design/rv32im_prefetch.sv
      - design/rv32im_irq_regs.sv
      - design/rv32im_bus_arbiter.sv
      - design/rv32im_wb_ram.sv
      - design/rv32im_fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_fetch_top.sv
